// File: design/gpio_consts.svh
// gpio constants: pin count, wishbone widths, register map and unmapped read value
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// pins on the block
`define GPIO_COUNT 16

// wishbone classic widths
`define WB_ADDR_W 8   // byte address
`define WB_DATA_W 32
`define WB_SEL_W  4   // one select per byte

// register byte offsets
`define GPIO_DIR_OFFSET           8'h00
`define GPIO_EN_OFFSET            8'h04
`define GPIO_IN_OFFSET            8'h08   // read only
`define GPIO_OUT_OFFSET           8'h0C
`define GPIO_TOGGLE_OFFSET        8'h10   // write pulse, reads zero
`define GPIO_INTRPT_EN_OFFSET     8'h14
`define GPIO_INTRPT_STATUS_OFFSET 8'h18   // clear on read
`define GPIO_INTRPT_EDGE_OFFSET   8'h1C   // last mapped register

// returned on reads outside the map
`define GPIO_BAD_RDATA 32'hBADCAB1E

`endif

// File: design/gpio_pkg.sv
// gpio package: register and arbiter enums, per-pin exchange structs
package gpio_pkg;

  //////////////////////////////////////////////////
  // register word indices
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    GPIO_REG_DIR           = 3'd0,
    GPIO_REG_EN            = 3'd1,
    GPIO_REG_IN            = 3'd2,
    GPIO_REG_OUT           = 3'd3,
    GPIO_REG_TOGGLE        = 3'd4,
    GPIO_REG_INTRPT_EN     = 3'd5,
    GPIO_REG_INTRPT_STATUS = 3'd6,
    GPIO_REG_INTRPT_EDGE   = 3'd7
  } gpio_reg_e;

  // arbiter grant state
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    GRANT_CPU = 2'd1,
    GRANT_DBG = 2'd2
  } arb_state_e;

  //////////////////////////////////////////////////
  // per-pin exchange
  //////////////////////////////////////////////////
  typedef struct packed {
    logic dir;          // 1 = output
    logic en;           // pin enabled
    logic out;          // output value
    logic toggle;       // one-cycle invert request
    logic intrpt_en;
    logic intrpt_edge;  // 1 = rising edge, 0 = high level
  } gpio_reg2hw_t;

  typedef struct packed {
    logic sync_in;      // synchronised pad input
    logic out_valid;    // load out into OUT
    logic out;
    logic intrpt_valid; // set status bit
  } gpio_hw2reg_t;

endpackage

// File: design/wb_bus.sv
// wishbone classic bus bundle between masters, arbiter and register slave
`include "gpio_consts.svh"

interface wb_bus;

  // master to slave
  logic                  cyc;    // cycle in progress
  logic                  stb;    // transfer strobe
  logic                  we;     // 1 = write
  logic [`WB_ADDR_W-1:0] adr;    // byte address
  logic [`WB_SEL_W-1:0]  sel;    // byte selects
  logic [`WB_DATA_W-1:0] dat_w;

  // slave to master
  logic [`WB_DATA_W-1:0] dat_r;
  logic                  ack;    // normal end
  logic                  err;    // error end

  modport master (
    output cyc, stb, we, adr, sel, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, sel, dat_w,
    output dat_r, ack, err
  );

endinterface

// File: design/wb_arbiter.sv
// wishbone arbiter: round-robin grant of cpu and debug masters onto one slave bus
module wb_arbiter (
  input  logic clk_i,
  input  logic rst_ni,
  wb_bus.slave  cpu_wb,
  wb_bus.slave  dbg_wb,
  wb_bus.master gpio_wb
);

  gpio_pkg::arb_state_e state_q, state_d;
  logic last_dbg_q, last_dbg_d; // debug port served last
  logic cpu_req, dbg_req;

  assign cpu_req = cpu_wb.cyc & cpu_wb.stb;
  assign dbg_req = dbg_wb.cyc & dbg_wb.stb;

  //////////////////////////////////////////////////
  // grant fsm
  //////////////////////////////////////////////////
  always_comb begin
    state_d    = state_q;
    last_dbg_d = last_dbg_q;
    case (state_q)
      gpio_pkg::IDLE: begin
        if (cpu_req && (!dbg_req || last_dbg_q)) begin // both asking: other side's turn
          state_d    = gpio_pkg::GRANT_CPU;
          last_dbg_d = 1'b0;
        end else if (dbg_req) begin
          state_d    = gpio_pkg::GRANT_DBG;
          last_dbg_d = 1'b1;
        end
      end
      gpio_pkg::GRANT_CPU: if (!cpu_wb.cyc) state_d = gpio_pkg::IDLE; // cycle over
      gpio_pkg::GRANT_DBG: if (!dbg_wb.cyc) state_d = gpio_pkg::IDLE;
      default:             state_d = gpio_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= gpio_pkg::IDLE;
      last_dbg_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      last_dbg_q <= last_dbg_d;
    end
  end

  //////////////////////////////////////////////////
  // request mux and response routing
  //////////////////////////////////////////////////
  always_comb begin
    // idle bus by default
    gpio_wb.cyc   = 1'b0;
    gpio_wb.stb   = 1'b0;
    gpio_wb.we    = 1'b0;
    gpio_wb.adr   = '0;
    gpio_wb.sel   = '0;
    gpio_wb.dat_w = '0;
    if (state_q == gpio_pkg::GRANT_CPU) begin
      gpio_wb.cyc   = cpu_wb.cyc;
      gpio_wb.stb   = cpu_wb.stb;
      gpio_wb.we    = cpu_wb.we;
      gpio_wb.adr   = cpu_wb.adr;
      gpio_wb.sel   = cpu_wb.sel;
      gpio_wb.dat_w = cpu_wb.dat_w;
    end else if (state_q == gpio_pkg::GRANT_DBG) begin
      gpio_wb.cyc   = dbg_wb.cyc;
      gpio_wb.stb   = dbg_wb.stb;
      gpio_wb.we    = dbg_wb.we;
      gpio_wb.adr   = dbg_wb.adr;
      gpio_wb.sel   = dbg_wb.sel;
      gpio_wb.dat_w = dbg_wb.dat_w;
    end
  end

  // losing port sees nothing, its transfer just stretches
  assign cpu_wb.ack   = (state_q == gpio_pkg::GRANT_CPU) & gpio_wb.ack;
  assign cpu_wb.err   = (state_q == gpio_pkg::GRANT_CPU) & gpio_wb.err;
  assign cpu_wb.dat_r = (state_q == gpio_pkg::GRANT_CPU) ? gpio_wb.dat_r : '0;
  assign dbg_wb.ack   = (state_q == gpio_pkg::GRANT_DBG) & gpio_wb.ack;
  assign dbg_wb.err   = (state_q == gpio_pkg::GRANT_DBG) & gpio_wb.err;
  assign dbg_wb.dat_r = (state_q == gpio_pkg::GRANT_DBG) ? gpio_wb.dat_r : '0;

endmodule

// File: design/gpio_regs.sv
// gpio register file: wishbone slave with byte-select writes, clear-on-read status and irq
`include "gpio_consts.svh"

module gpio_regs (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  wb_bus.slave                                     wb,
  output gpio_pkg::gpio_reg2hw_t [`GPIO_COUNT-1:0] reg2hw_o,
  input  gpio_pkg::gpio_hw2reg_t [`GPIO_COUNT-1:0] hw2reg_i,
  output logic                                     irq_o
);

  // bus side
  logic                  access;   // new transfer this cycle
  logic                  mapped;
  logic                  wr;
  logic                  rd_status;
  gpio_pkg::gpio_reg_e   reg_idx;
  logic [`WB_DATA_W-1:0] bit_mask;
  logic [`GPIO_COUNT-1:0] wmask, wdata;
  logic                  ack_q, err_q;
  logic [`GPIO_COUNT-1:0] rd_bits;
  logic [`WB_DATA_W-1:0] rdata_d, rdata_q;

  // register state
  logic [`GPIO_COUNT-1:0] dir_q, dir_d;
  logic [`GPIO_COUNT-1:0] en_q, en_d;
  logic [`GPIO_COUNT-1:0] in_q;
  logic [`GPIO_COUNT-1:0] out_q, out_d;
  logic [`GPIO_COUNT-1:0] ien_q, ien_d;
  logic [`GPIO_COUNT-1:0] status_q, status_d;
  logic [`GPIO_COUNT-1:0] edge_q, edge_d;
  logic [`GPIO_COUNT-1:0] toggle;
  logic                   irq_q;

  // pin side, unpacked per field
  logic [`GPIO_COUNT-1:0] hw_sync, hw_out, hw_out_valid, hw_intrpt;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////
  assign access    = wb.cyc & wb.stb & ~ack_q & ~err_q; // ack cycle never re-samples
  assign mapped    = {wb.adr[`WB_ADDR_W-1:2], 2'b00} <= `GPIO_INTRPT_EDGE_OFFSET;
  assign reg_idx   = gpio_pkg::gpio_reg_e'(wb.adr[4:2]);
  assign wr        = access & mapped & wb.we;
  assign rd_status = access & mapped & ~wb.we & (reg_idx == gpio_pkg::GPIO_REG_INTRPT_STATUS);

  always_comb begin
    for (int b = 0; b < `WB_SEL_W; b++) begin
      bit_mask[8*b +: 8] = {8{wb.sel[b]}}; // whole byte per select
    end
  end
  assign wmask = bit_mask[`GPIO_COUNT-1:0];
  assign wdata = wb.dat_w[`GPIO_COUNT-1:0] & wmask;

  always_comb begin
    for (int i = 0; i < `GPIO_COUNT; i++) begin
      hw_sync[i]      = hw2reg_i[i].sync_in;
      hw_out[i]       = hw2reg_i[i].out;
      hw_out_valid[i] = hw2reg_i[i].out_valid;
      hw_intrpt[i]    = hw2reg_i[i].intrpt_valid;
    end
  end

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////
  always_comb begin
    dir_d    = dir_q;
    en_d     = en_q;
    ien_d    = ien_q;
    edge_d   = edge_q;
    out_d    = (out_q & ~hw_out_valid) | (hw_out & hw_out_valid); // toggle result from pins
    status_d = status_q | hw_intrpt;                              // sticky
    toggle   = '0;
    if (wr) begin
      case (reg_idx)
        gpio_pkg::GPIO_REG_DIR:         dir_d  = (dir_q & ~wmask) | wdata;
        gpio_pkg::GPIO_REG_EN:          en_d   = (en_q & ~wmask) | wdata;
        gpio_pkg::GPIO_REG_OUT:         out_d  = (out_q & ~wmask) | wdata;
        gpio_pkg::GPIO_REG_TOGGLE:      toggle = wdata;               // single pulse
        gpio_pkg::GPIO_REG_INTRPT_EN:   ien_d  = (ien_q & ~wmask) | wdata;
        gpio_pkg::GPIO_REG_INTRPT_EDGE: edge_d = (edge_q & ~wmask) | wdata;
        default: ;                                                    // IN, STATUS read only
      endcase
    end
    if (rd_status) status_d = hw_intrpt; // clear, but keep what fires now
  end

  // read mux, sampled with the request
  always_comb begin
    case (reg_idx)
      gpio_pkg::GPIO_REG_DIR:           rd_bits = dir_q;
      gpio_pkg::GPIO_REG_EN:            rd_bits = en_q;
      gpio_pkg::GPIO_REG_IN:            rd_bits = in_q;
      gpio_pkg::GPIO_REG_OUT:           rd_bits = out_q;
      gpio_pkg::GPIO_REG_INTRPT_EN:     rd_bits = ien_q;
      gpio_pkg::GPIO_REG_INTRPT_STATUS: rd_bits = status_q;
      gpio_pkg::GPIO_REG_INTRPT_EDGE:   rd_bits = edge_q;
      default:                          rd_bits = '0; // toggle reads zero
    endcase
    if (!mapped)    rdata_d = `GPIO_BAD_RDATA;
    else if (wb.we) rdata_d = '0;
    else            rdata_d = {{(`WB_DATA_W-`GPIO_COUNT){1'b0}}, rd_bits};
  end

  //////////////////////////////////////////////////
  // flops
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      dir_q    <= '0;
      en_q     <= '0;
      in_q     <= '0;
      out_q    <= '0;
      ien_q    <= '0;
      status_q <= '0;
      edge_q   <= '0;
      irq_q    <= 1'b0;
    end else begin
      ack_q    <= access & mapped;  // high for one cycle only
      err_q    <= access & ~mapped;
      dir_q    <= dir_d;
      en_q     <= en_d;
      in_q     <= hw_sync;          // one cycle behind the synchroniser
      out_q    <= out_d;
      ien_q    <= ien_d;
      status_q <= status_d;
      edge_q   <= edge_d;
      irq_q    <= |status_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) rdata_q <= rdata_d;
  end

  assign wb.ack   = ack_q;
  assign wb.err   = err_q;
  assign wb.dat_r = rdata_q;
  assign irq_o    = irq_q;

  always_comb begin
    for (int i = 0; i < `GPIO_COUNT; i++) begin
      reg2hw_o[i].dir         = dir_q[i];
      reg2hw_o[i].en          = en_q[i];
      reg2hw_o[i].out         = out_q[i];
      reg2hw_o[i].toggle      = toggle[i];
      reg2hw_o[i].intrpt_en   = ien_q[i];
      reg2hw_o[i].intrpt_edge = edge_q[i];
    end
  end

endmodule

// File: design/gpio_pins.sv
// gpio pin logic: input synchronisers, pad drive, toggling and interrupt detection
`include "gpio_consts.svh"

module gpio_pins (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [`GPIO_COUNT-1:0]                   gpio_in_i,
  output logic [`GPIO_COUNT-1:0]                   gpio_out_o,
  output logic [`GPIO_COUNT-1:0]                   gpio_oe_o,
  input  gpio_pkg::gpio_reg2hw_t [`GPIO_COUNT-1:0] reg2hw_i,
  output gpio_pkg::gpio_hw2reg_t [`GPIO_COUNT-1:0] hw2reg_o
);

  logic [`GPIO_COUNT-1:0] sync1_q;  // first stage, may be metastable
  logic [`GPIO_COUNT-1:0] sync2_q;  // safe to use
  logic [`GPIO_COUNT-1:0] prev_q;   // last synced value
  logic [`GPIO_COUNT-1:0] rise;

  //////////////////////////////////////////////////
  // input synchroniser and edge history
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~prev_q; // low to high seen this cycle

  //////////////////////////////////////////////////
  // per pin
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < `GPIO_COUNT; i++) begin
      hw2reg_o[i].sync_in   = sync2_q[i];

      // toggle loads the inverted output back into OUT
      hw2reg_o[i].out_valid = reg2hw_i[i].toggle;
      hw2reg_o[i].out       = ~reg2hw_i[i].out;

      // edge or level, per pin
      if (reg2hw_i[i].intrpt_edge) begin
        hw2reg_o[i].intrpt_valid = reg2hw_i[i].intrpt_en & rise[i];
      end else begin
        hw2reg_o[i].intrpt_valid = reg2hw_i[i].intrpt_en & sync2_q[i];
      end

      // disabled pins stay quiet
      gpio_out_o[i] = reg2hw_i[i].out & reg2hw_i[i].en;
      gpio_oe_o[i]  = reg2hw_i[i].dir & reg2hw_i[i].en;
    end
  end

endmodule

// File: design/gpio_top.sv
// gpio top: two wishbone masters, arbiter, register file and pin logic
`include "gpio_consts.svh"

module gpio_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // cpu master
  input  logic                   cpu_cyc_i,
  input  logic                   cpu_stb_i,
  input  logic                   cpu_we_i,
  input  logic [`WB_ADDR_W-1:0]  cpu_adr_i,
  input  logic [`WB_SEL_W-1:0]   cpu_sel_i,
  input  logic [`WB_DATA_W-1:0]  cpu_dat_i,
  output logic [`WB_DATA_W-1:0]  cpu_dat_o,
  output logic                   cpu_ack_o,
  output logic                   cpu_err_o,
  // debug master
  input  logic                   dbg_cyc_i,
  input  logic                   dbg_stb_i,
  input  logic                   dbg_we_i,
  input  logic [`WB_ADDR_W-1:0]  dbg_adr_i,
  input  logic [`WB_SEL_W-1:0]   dbg_sel_i,
  input  logic [`WB_DATA_W-1:0]  dbg_dat_i,
  output logic [`WB_DATA_W-1:0]  dbg_dat_o,
  output logic                   dbg_ack_o,
  output logic                   dbg_err_o,
  // pads
  input  logic [`GPIO_COUNT-1:0] gpio_in_i,
  output logic [`GPIO_COUNT-1:0] gpio_out_o,
  output logic [`GPIO_COUNT-1:0] gpio_oe_o,
  output logic                   irq_o
);

  wb_bus cpu_bus ();
  wb_bus dbg_bus ();
  wb_bus gpio_bus (); // shared, after the arbiter

  gpio_pkg::gpio_reg2hw_t [`GPIO_COUNT-1:0] reg2hw;
  gpio_pkg::gpio_hw2reg_t [`GPIO_COUNT-1:0] hw2reg;

  // plain ports onto the bus bundles
  assign cpu_bus.cyc   = cpu_cyc_i;
  assign cpu_bus.stb   = cpu_stb_i;
  assign cpu_bus.we    = cpu_we_i;
  assign cpu_bus.adr   = cpu_adr_i;
  assign cpu_bus.sel   = cpu_sel_i;
  assign cpu_bus.dat_w = cpu_dat_i;
  assign cpu_dat_o     = cpu_bus.dat_r;
  assign cpu_ack_o     = cpu_bus.ack;
  assign cpu_err_o     = cpu_bus.err;

  assign dbg_bus.cyc   = dbg_cyc_i;
  assign dbg_bus.stb   = dbg_stb_i;
  assign dbg_bus.we    = dbg_we_i;
  assign dbg_bus.adr   = dbg_adr_i;
  assign dbg_bus.sel   = dbg_sel_i;
  assign dbg_bus.dat_w = dbg_dat_i;
  assign dbg_dat_o     = dbg_bus.dat_r;
  assign dbg_ack_o     = dbg_bus.ack;
  assign dbg_err_o     = dbg_bus.err;

  wb_arbiter wb_arbiter_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cpu_wb  (cpu_bus.slave),
    .dbg_wb  (dbg_bus.slave),
    .gpio_wb (gpio_bus.master)
  );

  gpio_regs gpio_regs_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb       (gpio_bus.slave),
    .reg2hw_o (reg2hw),
    .hw2reg_i (hw2reg),
    .irq_o    (irq_o)
  );

  gpio_pins gpio_pins_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .reg2hw_i   (reg2hw),
    .hw2reg_o   (hw2reg)
  );

endmodule

// File: test/gpio_tb.sv
// gpio testbench driving seeded random traffic on cpu and debug ports against a register model
`include "gpio_consts.svh"

module gpio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   cpu_cyc_i, cpu_stb_i, cpu_we_i, cpu_ack_o, cpu_err_o;
  logic                   dbg_cyc_i, dbg_stb_i, dbg_we_i, dbg_ack_o, dbg_err_o;
  logic [`WB_ADDR_W-1:0]  cpu_adr_i, dbg_adr_i;
  logic [`WB_SEL_W-1:0]   cpu_sel_i, dbg_sel_i;
  logic [`WB_DATA_W-1:0]  cpu_dat_i, cpu_dat_o, dbg_dat_i, dbg_dat_o;
  logic [`GPIO_COUNT-1:0] gpio_in_i, gpio_out_o, gpio_oe_o;
  logic                   irq_o;

  int seed = 24230;
  int checks = 0;
  int errors = 0;
  int checks_at_start, errors_at_start;          // per test deltas
  string test_name = "";                         // test now running
  logic [`GPIO_COUNT-1:0] model [8];             // expected read value per register word
  gpio_pkg::gpio_reg_e    rw_regs [5] = '{gpio_pkg::GPIO_REG_DIR, gpio_pkg::GPIO_REG_EN,
    gpio_pkg::GPIO_REG_OUT, gpio_pkg::GPIO_REG_INTRPT_EN, gpio_pkg::GPIO_REG_INTRPT_EDGE};

  gpio_top gpio_top_i (.*);

  always #20 clk_i = ~clk_i; // 40 ns period

  //////////////////////////////////////////////////
  // compare tasks and reporting
  //////////////////////////////////////////////////
  task automatic check_data(input string name, input logic [`WB_DATA_W-1:0] exp,
                            input logic [`WB_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_pins(input string name, input logic [`GPIO_COUNT-1:0] exp,
                            input logic [`GPIO_COUNT-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %b, actual %b", test_name, name, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", test_name, checks - checks_at_start,
             errors - errors_at_start);
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // bus transfers, one task per port
  //////////////////////////////////////////////////
  task automatic cpu_xfer(input logic we, input logic [`WB_ADDR_W-1:0] adr,
                          input logic [`WB_SEL_W-1:0] sel, input logic [`WB_DATA_W-1:0] wd,
                          output logic [`WB_DATA_W-1:0] rd, output logic er);
    int n;
    @(posedge clk_i);
    #2;
    {cpu_cyc_i, cpu_stb_i, cpu_we_i} = {2'b11, we};
    {cpu_adr_i, cpu_sel_i, cpu_dat_i} = {adr, sel, wd};
    n = 0;
    @(negedge clk_i);                          // responses are stable mid-cycle
    while (!(cpu_ack_o || cpu_err_o)) begin
      n++;
      if (n >= 50) abort_run("cpu port transfer got neither ack nor err");
      @(negedge clk_i);
    end
    rd = cpu_dat_o;
    er = cpu_err_o;
    @(posedge clk_i);
    #2;
    {cpu_cyc_i, cpu_stb_i} = 2'b00; // end of cycle lets the arbiter release
  endtask

  task automatic dbg_xfer(input logic we, input logic [`WB_ADDR_W-1:0] adr,
                          input logic [`WB_SEL_W-1:0] sel, input logic [`WB_DATA_W-1:0] wd,
                          output logic [`WB_DATA_W-1:0] rd, output logic er);
    int n;
    @(posedge clk_i);
    #2;
    {dbg_cyc_i, dbg_stb_i, dbg_we_i} = {2'b11, we};
    {dbg_adr_i, dbg_sel_i, dbg_dat_i} = {adr, sel, wd};
    n = 0;
    @(negedge clk_i);
    while (!(dbg_ack_o || dbg_err_o)) begin
      n++;
      if (n >= 50) abort_run("debug port transfer got neither ack nor err");
      @(negedge clk_i);
    end
    rd = dbg_dat_o;
    er = dbg_err_o;
    @(posedge clk_i);
    #2;
    {dbg_cyc_i, dbg_stb_i} = 2'b00;
  endtask

  task automatic do_xfer(input bit dbg, input logic we, input logic [`WB_ADDR_W-1:0] adr,
                         input logic [`WB_SEL_W-1:0] sel, input logic [`WB_DATA_W-1:0] wd,
                         output logic [`WB_DATA_W-1:0] rd, output logic er);
    if (dbg) dbg_xfer(we, adr, sel, wd, rd, er);
    else     cpu_xfer(we, adr, sel, wd, rd, er);
  endtask

  //////////////////////////////////////////////////
  // register model
  //////////////////////////////////////////////////
  function automatic logic [`WB_ADDR_W-1:0] reg_adr(input gpio_pkg::gpio_reg_e r);
    return {3'b000, r, 2'b00}; // word index to byte offset
  endfunction

  function automatic logic [`GPIO_COUNT-1:0] byte_mask(input logic [`WB_SEL_W-1:0] sel);
    return {{8{sel[1]}}, {8{sel[0]}}}; // upper selects fall beyond the 16 pins
  endfunction

  task automatic write_reg(input bit dbg, input gpio_pkg::gpio_reg_e r,
                           input logic [`WB_SEL_W-1:0] sel, input logic [`WB_DATA_W-1:0] d);
    logic [`WB_DATA_W-1:0] rd;
    logic                  er;
    logic [`GPIO_COUNT-1:0] m;
    m = byte_mask(sel);
    do_xfer(dbg, 1'b1, reg_adr(r), sel, d, rd, er);
    check_bit($sformatf("write %s err", r.name()), 1'b0, er);
    if (r == gpio_pkg::GPIO_REG_TOGGLE)
      model[gpio_pkg::GPIO_REG_OUT] ^= d[`GPIO_COUNT-1:0] & m; // selected bits flip
    else
      model[r] = (model[r] & ~m) | (d[`GPIO_COUNT-1:0] & m);
  endtask

  task automatic read_reg(input bit dbg, input gpio_pkg::gpio_reg_e r);
    logic [`WB_DATA_W-1:0] rd;
    logic                  er;
    do_xfer(dbg, 1'b0, reg_adr(r), 4'hF, '0, rd, er);
    check_bit($sformatf("read %s err", r.name()), 1'b0, er);
    check_data($sformatf("read %s", r.name()), {16'h0, model[r]}, rd);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [`WB_DATA_W-1:0]  rd, cd, dd;
    logic                   er, cwe, dwe;
    logic [`WB_SEL_W-1:0]   csel, dsel;
    logic [`GPIO_COUNT-1:0] pat;
    logic [`WB_ADDR_W-1:0]  adr;
    gpio_pkg::gpio_reg_e    r, cr, dr;
    {cpu_cyc_i, cpu_stb_i, cpu_we_i, cpu_adr_i, cpu_sel_i, cpu_dat_i} = '0;
    {dbg_cyc_i, dbg_stb_i, dbg_we_i, dbg_adr_i, dbg_sel_i, dbg_dat_i} = '0;
    gpio_in_i = '0;
    rst_ni    = 1'b0;
    for (int i = 0; i < 8; i++) model[i] = '0; // every register resets to zero
    wait_cycles(2);
    #2 rst_ni = 1'b1;

    // byte-select writes and read-back
    start_test("regs_rw");
    @(negedge clk_i);
    check_bit("irq after reset", 1'b0, irq_o);
    check_pins("oe after reset", '0, gpio_oe_o);
    check_pins("out after reset", '0, gpio_out_o);
    for (int i = 0; i < 30; i++) begin
      r = rw_regs[$unsigned($random(seed)) % 5];
      write_reg($random(seed) & 1, r, $random(seed), $random(seed));
      read_reg($random(seed) & 1, r);
    end
    finish_test();

    // pad drive and toggle
    start_test("pads");
    write_reg(1'b0, gpio_pkg::GPIO_REG_DIR, 4'hF, $random(seed));
    write_reg(1'b1, gpio_pkg::GPIO_REG_EN, 4'hF, $random(seed));
    write_reg(1'b0, gpio_pkg::GPIO_REG_OUT, 4'hF, $random(seed));
    @(negedge clk_i);
    check_pins("gpio_out", model[gpio_pkg::GPIO_REG_OUT] & model[gpio_pkg::GPIO_REG_EN],
               gpio_out_o);
    check_pins("gpio_oe", model[gpio_pkg::GPIO_REG_DIR] & model[gpio_pkg::GPIO_REG_EN], gpio_oe_o);
    write_reg(1'b1, gpio_pkg::GPIO_REG_TOGGLE, $random(seed), $random(seed));
    read_reg(1'b0, gpio_pkg::GPIO_REG_OUT);
    @(negedge clk_i);
    check_pins("toggled out", model[gpio_pkg::GPIO_REG_OUT] & model[gpio_pkg::GPIO_REG_EN],
               gpio_out_o);
    read_reg(1'b1, gpio_pkg::GPIO_REG_TOGGLE); // model keeps zero here
    finish_test();

    // input sampling through the synchroniser
    start_test("input");
    @(posedge clk_i);
    #2 gpio_in_i = $random(seed);
    wait_cycles(5);
    model[gpio_pkg::GPIO_REG_IN] = gpio_in_i;
    read_reg(1'b0, gpio_pkg::GPIO_REG_IN);
    finish_test();

    // interrupts from quiet pins and empty status
    start_test("interrupts");
    @(posedge clk_i);
    #2 gpio_in_i = '0;
    write_reg(1'b0, gpio_pkg::GPIO_REG_INTRPT_EN, 4'hF, '0);
    wait_cycles(5);
    do_xfer(1'b0, 1'b0, reg_adr(gpio_pkg::GPIO_REG_INTRPT_STATUS), 4'hF, '0, rd, er);
    write_reg(1'b1, gpio_pkg::GPIO_REG_INTRPT_EDGE, 4'hF, $random(seed));
    write_reg(1'b0, gpio_pkg::GPIO_REG_INTRPT_EN, 4'hF, $random(seed) | 1);
    pat = $random(seed) | 1; // pin 0 always fires
    @(posedge clk_i);
    #2 gpio_in_i = pat;
    wait_cycles(5);
    @(negedge clk_i);
    check_bit("irq raised", 1'b1, irq_o);
    model[gpio_pkg::GPIO_REG_INTRPT_STATUS] = model[gpio_pkg::GPIO_REG_INTRPT_EN] & pat;
    read_reg(1'b1, gpio_pkg::GPIO_REG_INTRPT_STATUS);
    @(posedge clk_i);
    #2 gpio_in_i = '0;
    wait_cycles(5);
    // level pins kept setting status until the input fell
    model[gpio_pkg::GPIO_REG_INTRPT_STATUS] = model[gpio_pkg::GPIO_REG_INTRPT_EN] &
                                               ~model[gpio_pkg::GPIO_REG_INTRPT_EDGE] & pat;
    read_reg(1'b0, gpio_pkg::GPIO_REG_INTRPT_STATUS);
    wait_cycles(1);
    @(negedge clk_i);
    check_bit("irq cleared", 1'b0, irq_o);
    model[gpio_pkg::GPIO_REG_INTRPT_STATUS] = '0;
    read_reg(1'b1, gpio_pkg::GPIO_REG_INTRPT_STATUS);
    finish_test();

    // unmapped offsets end with err
    start_test("unmapped");
    for (int i = 0; i < 4; i++) begin
      adr = 8'h20 | ($random(seed) & 8'hDC); // aligned offsets from 0x20 up
      do_xfer($random(seed) & 1, 1'b1, adr, 4'hF, $random(seed), rd, er);
      check_bit("unmapped write err", 1'b1, er);
      do_xfer($random(seed) & 1, 1'b0, adr, 4'hF, '0, rd, er);
      check_bit("unmapped read err", 1'b1, er);
      check_data("unmapped read data", `GPIO_BAD_RDATA, rd);
    end
    for (int i = 0; i < 5; i++) read_reg(1'b0, rw_regs[i]);
    finish_test();

    // both ports at once with cpu on DIR/EN and debug on OUT/EDGE
    start_test("concurrent");
    for (int i = 0; i < 20; i++) begin
      cr   = ($random(seed) & 1) ? gpio_pkg::GPIO_REG_EN : gpio_pkg::GPIO_REG_DIR;
      dr   = ($random(seed) & 1) ? gpio_pkg::GPIO_REG_INTRPT_EDGE : gpio_pkg::GPIO_REG_OUT;
      cwe  = $random(seed);
      dwe  = $random(seed);
      csel = $random(seed);
      dsel = $random(seed);
      cd   = $random(seed);
      dd   = $random(seed);
      fork
        begin
          if (cwe) write_reg(1'b0, cr, csel, cd);
          else     read_reg(1'b0, cr);
        end
        begin
          if (dwe) write_reg(1'b1, dr, dsel, dd);
          else     read_reg(1'b1, dr);
        end
      join
    end
    for (int i = 0; i < 5; i++) read_reg(i & 1, rw_regs[i]);
    finish_test();

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+design
design/gpio_pkg.sv
design/wb_bus.sv
design/wb_arbiter.sv
design/gpio_regs.sv
design/gpio_pins.sv
design/gpio_top.sv
test/gpio_tb.sv
